/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= tb
FILELIST ?= tb.f
OBJDIR   ?= obj_dir
PASS_MSG := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* bpPkg.sv */
`default_nettype none

package bpPkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // pc width of the fetch path
  localparam int xlen = 32;

  //////////////////////////////
  // pipeline control
  //////////////////////////////

  // stall and flush levels of one stage
  typedef struct packed {
    logic stall;
    logic flush;
  } stageCtrlT;

  // one copy per stage, f sits in the top bits
  typedef struct packed {
    stageCtrlT f;
    stageCtrlT d;
    stageCtrlT e;
    stageCtrlT m;
    stageCtrlT w;
  } pipeCtrlT;

  //////////////////////////////
  // branch record and counter
  //////////////////////////////

  // per-stage branch record, taken only meaningful from m onward
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic            isBranch;
    logic            taken;
  } brRecT;

  // 2-bit saturating counter, bit 1 is the predicted direction
  typedef logic [1:0] ctrStateT;

endpackage

`default_nettype wire

/* branchDirUnit.sv */
`default_nettype none

module branchDirUnit #(
  // 2^m local history entries
  parameter int m = 6,
  // history length, also pht index width
  parameter int k = 10
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  bpPkg::pipeCtrlT        ctrl,
  input  logic [bpPkg::xlen-1:0] pcNextF,
  // decoded record entering d
  input  bpPkg::brRecT           brD,
  input  logic                   takenE,
  output bpPkg::ctrStateT        dirPredD,
  output logic                   dirWrongE
);

  // slots 0..2 hold the e, m and w records
  bpPkg::stageCtrlT recCtrl [3];
  bpPkg::brRecT     recIn [3];
  bpPkg::brRecT     recQ [3];

  //////////////////////////////
  // record pipeline
  //////////////////////////////

  assign recCtrl[0] = ctrl.e;
  assign recCtrl[1] = ctrl.m;
  assign recCtrl[2] = ctrl.w;

  always_comb begin
    recIn[0] = brD;
    // resolved direction joins the record on its way to m
    recIn[1].pc       = recQ[0].pc;
    recIn[1].isBranch = recQ[0].isBranch;
    recIn[1].taken    = takenE;
    recIn[2] = recQ[1];
  end

  // hold on stall, clear on flush
  always_ff @(posedge clk) begin
    for (int s = 0; s < 3; s++) begin
      if (!rstN || recCtrl[s].flush) begin
        recQ[s] <= '0;
      end else if (!recCtrl[s].stall) begin
        recQ[s] <= recIn[s];
      end
    end
  end

  //////////////////////////////
  // predictor
  //////////////////////////////

  localRepairBp #(.m(m), .k(k)) bp (
    .clk       (clk),
    .rstN      (rstN),
    .ctrl      (ctrl),
    .pcNextF   (pcNextF),
    .recD      (brD),
    .recE      (recQ[0]),
    .recM      (recQ[1]),
    .recW      (recQ[2]),
    .takenE    (takenE),
    .dirPredD  (dirPredD),
    .dirWrongE (dirWrongE)
  );

endmodule

`default_nettype wire

/* histRam.sv */
`default_nettype none

module histRam #(
  parameter int depthLog2 = 6,
  parameter int width = 10
) (
  input  logic                 clk,
  input  logic                 rstN,
  // read port, registered
  input  logic                 rdEn,
  input  logic [depthLog2-1:0] rdAddr,
  output logic [width-1:0]     rdData,
  // write port
  input  logic                 wrEn,
  input  logic [depthLog2-1:0] wrAddr,
  input  logic [width-1:0]     wrData
);

  // storage array, 2^depthLog2 words
  logic [width-1:0] mem [2**depthLog2];

  //////////////////////////////
  // read and write
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      // tables start from a known state
      // counters land on strongly not taken
      mem    <= '{default: '0};
      rdData <= '0;
    end else begin
      // read register only moves when the stage moves
      // same-cycle write to this address is not seen yet
      if (rdEn) begin
        rdData <= mem[rdAddr];
      end
      // write lands on this edge
      if (wrEn) begin
        mem[wrAddr] <= wrData;
      end
    end
  end

endmodule

`default_nettype wire

/* localRepairBp.sv */
`default_nettype none

module localRepairBp #(
  parameter int m = 6,
  parameter int k = 10
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  bpPkg::pipeCtrlT        ctrl,
  input  logic [bpPkg::xlen-1:0] pcNextF,
  // branch records per stage
  input  bpPkg::brRecT           recD,
  input  bpPkg::brRecT           recE,
  input  bpPkg::brRecT           recM,
  input  bpPkg::brRecT           recW,
  input  logic                   takenE,
  output bpPkg::ctrStateT        dirPredD,
  output logic                   dirWrongE
);

  // history and counter carried by one stage
  typedef struct packed {
    logic [k-1:0]    hist;
    bpPkg::ctrStateT pred;
  } slotT;

  // folded pc index, top bit mixes in pc[1] for compressed code
  function automatic logic [m-1:0] foldIdx(input logic [bpPkg::xlen-1:0] pc);
    return {pc[m+1] ^ pc[1], pc[m:2]};
  endfunction

  // saturating step, holds at 0 and 3
  function automatic bpPkg::ctrStateT satNext(input bpPkg::ctrStateT cur,
                                              input logic taken);
    bpPkg::ctrStateT nxt;
    nxt = cur;
    if (taken && cur != 2'b11) begin
      nxt = cur + 2'd1;
    end else if (!taken && cur != 2'b00) begin
      nxt = cur - 2'd1;
    end
    return nxt;
  endfunction

  logic [m-1:0]     idxF;
  logic [m-1:0]     idxE;
  logic [m-1:0]     idxW;
  logic [k-1:0]     histCommittedF;
  logic [k-1:0]     histSpecF;
  logic             specValidF;
  logic [k-1:0]     histF;
  logic [k-1:0]     histD;
  logic             shbWrEn;
  logic             commitEn;
  bpPkg::stageCtrlT slotCtrl [3];
  slotT             slotIn [3];
  slotT             slotQ [3];

  //////////////////////////////
  // fetch: history lookup
  //////////////////////////////

  assign idxF = foldIdx(pcNextF);
  assign idxE = foldIdx(recE.pc);
  assign idxW = foldIdx(recW.pc);

  // committed history, written from resolved branches in w
  histRam #(.depthLog2(m), .width(k)) bht (
    .clk    (clk),
    .rstN   (rstN),
    .rdEn   (!ctrl.f.stall),
    .rdAddr (idxF),
    .rdData (histCommittedF),
    .wrEn   (commitEn),
    .wrAddr (idxW),
    .wrData ({recW.taken, slotQ[2].hist[k-1:1]})
  );

  // speculative history buffer
  // the d branch handed to e writes it, indexed by the e pc
  assign shbWrEn = recD.isBranch && !ctrl.e.stall && !ctrl.e.flush;

  histRam #(.depthLog2(m), .width(k)) shb (
    .clk    (clk),
    .rstN   (rstN),
    .rdEn   (!ctrl.f.stall),
    .rdAddr (idxF),
    .rdData (histSpecF),
    .wrEn   (shbWrEn),
    .wrAddr (idxE),
    .wrData ({dirPredD[1], slotQ[0].hist[k-1:1]})
  );

  // marks which shb entries survived the last d flush
  specValidBits #(.m(m)) specValid (
    .clk    (clk),
    .rstN   (rstN),
    .ctrl   (ctrl),
    .rdIdx  (idxF),
    .valid  (specValidF),
    .setIdx (idxE),
    .set    (shbWrEn)
  );

  // stale speculative entry falls back to committed copy
  assign histF = specValidF ? histSpecF : histCommittedF;

  //////////////////////////////
  // pattern history table
  //////////////////////////////

  // counters train only once the branch reaches w
  assign commitEn = recW.isBranch && !ctrl.w.stall && !ctrl.w.flush;

  histRam #(.depthLog2(k), .width(2)) pht (
    .clk    (clk),
    .rstN   (rstN),
    .rdEn   (!ctrl.d.stall),
    .rdAddr (histF),
    .rdData (dirPredD),
    .wrEn   (commitEn),
    .wrAddr (slotQ[2].hist),
    .wrData (slotQ[2].pred)
  );

  //////////////////////////////
  // history and counter pipeline
  //////////////////////////////

  // d only carries history, the counter read lands in d itself
  always_ff @(posedge clk) begin
    if (!rstN || ctrl.d.flush) begin
      histD <= '0;
    end else if (!ctrl.d.stall) begin
      histD <= histF;
    end
  end

  // slots 0..2 are e, m and w
  assign slotCtrl[0] = ctrl.e;
  assign slotCtrl[1] = ctrl.m;
  assign slotCtrl[2] = ctrl.w;

  always_comb begin
    slotIn[0].hist = histD;
    slotIn[0].pred = dirPredD;
    slotIn[1]      = slotQ[0];
    // w carries the already updated counter
    slotIn[2].hist = slotQ[1].hist;
    slotIn[2].pred = satNext(slotQ[1].pred, recM.taken);
  end

  always_ff @(posedge clk) begin
    for (int s = 0; s < 3; s++) begin
      if (!rstN || slotCtrl[s].flush) begin
        slotQ[s] <= '0;
      end else if (!slotCtrl[s].stall) begin
        slotQ[s] <= slotIn[s];
      end
    end
  end

  // resolved direction against e's prediction
  assign dirWrongE = recE.isBranch && (takenE != slotQ[0].pred[1]);

endmodule

`default_nettype wire

/* specValidBits.sv */
`default_nettype none

module specValidBits #(
  parameter int m = 6
) (
  input  logic            clk,
  input  logic            rstN,
  input  bpPkg::pipeCtrlT ctrl,
  // fetch side lookup
  input  logic [m-1:0]    rdIdx,
  output logic            valid,
  // speculative write side
  input  logic [m-1:0]    setIdx,
  input  logic            set
);

  // one bit per speculative history entry
  logic [2**m-1:0] validArr;

  //////////////////////////////
  // valid array
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validArr <= '0;
      valid    <= 1'b0;
    end else begin
      // lookup follows the history table read port
      // so it holds with f
      if (!ctrl.f.stall) begin
        valid <= validArr[rdIdx];
      end
      // repair step, a d flush drops every speculative entry
      // fetch then falls back on committed history
      if (ctrl.d.flush) begin
        validArr <= '0;
      end
      // the branch leaving d moves on to e
      // so its entry is good even in a flush cycle
      if (set) begin
        validArr[setIdx] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb.f */
bpPkg.sv
histRam.sv
specValidBits.sv
localRepairBp.sv
branchDirUnit.sv
tb_props.sv
tb.sv

/* tb.sv */
`default_nettype none

module tb;

  localparam int idxBits = 6;
  localparam int histBits = 10;
  localparam int cycleLimit = 10000;
  // two branches at separate history entries
  localparam logic [bpPkg::xlen-1:0] pcA = 32'h0000_0104;
  localparam logic [bpPkg::xlen-1:0] pcB = 32'h0000_0240;

  // history and counter carried by one model stage
  typedef struct packed {
    logic [histBits-1:0] hist;
    bpPkg::ctrStateT     pred;
  } slotT;

  logic                   clk;
  logic                   rstN;
  bpPkg::pipeCtrlT        ctrl;
  logic [bpPkg::xlen-1:0] pcNextF;
  bpPkg::brRecT           brD;
  logic                   takenE;
  bpPkg::ctrStateT        dirPredD;
  logic                   dirWrongE;

  logic [31:0]  lfsrState;
  bpPkg::brRecT fetchRec;
  bpPkg::brRecT decodeRec;
  int           dirMode;
  logic         altA;
  logic         pendingWrong;
  int           cycleNo;
  int           checkCount;
  int           errCount;
  int           eBranches;
  int           flushCount;
  int           testErr;
  int           testChecks;
  int           tries;

  // reference model state
  logic [histBits-1:0]      mBht [2**idxBits];
  logic [histBits-1:0]      mShb [2**idxBits];
  bpPkg::ctrStateT          mPht [2**histBits];
  logic [2**idxBits-1:0]    mValidArr;
  logic [histBits-1:0]      mBhtRd;
  logic [histBits-1:0]      mShbRd;
  logic                     mValidQ;
  bpPkg::ctrStateT          mPred;
  logic [histBits-1:0]      mHistD;
  slotT                     mSlot [3];
  bpPkg::brRecT             mRec [3];

  branchDirUnit #(.m(idxBits), .k(histBits)) u_dut (
    .clk       (clk),
    .rstN      (rstN),
    .ctrl      (ctrl),
    .pcNextF   (pcNextF),
    .brD       (brD),
    .takenE    (takenE),
    .dirPredD  (dirPredD),
    .dirWrongE (dirWrongE)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // hard stop in case a loop never ends
  initial begin
    for (int i = 0; i < cycleLimit; i++) begin
      @(posedge clk);
    end
    $display("watchdog expired before the last test finished");
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////
  // random bits
  //////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  // high one time in four
  function automatic logic quarterBit();
    logic [31:0] r;
    r = randBits(2);
    return r[1:0] == 2'b00;
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic logic [idxBits-1:0] foldedIndex(input logic [bpPkg::xlen-1:0] pc);
    return {pc[idxBits+1] ^ pc[1], pc[idxBits:2]};
  endfunction

  function automatic bpPkg::ctrStateT satCount(input bpPkg::ctrStateT c, input logic taken);
    if (taken) begin
      return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
  endfunction

  // outcome of the branch in e, per test mode
  function automatic logic resolveDir(input bpPkg::brRecT rec);
    logic [31:0] r;
    logic        dir;
    dir = 1'b0;
    if (rec.isBranch && dirMode == 0) begin
      dir = 1'b1;
    end else if (rec.isBranch && dirMode == 1) begin
      // pcA alternates, anything else is always taken
      dir = 1'b1;
      if (rec.pc == pcA) begin
        altA = ~altA;
        dir = altA;
      end
    end else if (rec.isBranch) begin
      r = randBits(1);
      dir = r[0];
    end
    return dir;
  endfunction

  task automatic modelStep();
    logic [idxBits-1:0]  iF;
    logic [idxBits-1:0]  iE;
    logic [idxBits-1:0]  iW;
    logic [histBits-1:0] hF;
    logic                shbWr;
    logic                commit;
    bpPkg::ctrStateT     predNext;
    if (!rstN) begin
      for (int i = 0; i < 2**idxBits; i++) begin
        mBht[i] = '0;
        mShb[i] = '0;
      end
      for (int i = 0; i < 2**histBits; i++) begin
        mPht[i] = '0;
      end
      mValidArr = '0;
      mBhtRd = '0;
      mShbRd = '0;
      mValidQ = 1'b0;
      mPred = '0;
      mHistD = '0;
      mSlot = '{default: '0};
      mRec = '{default: '0};
    end else begin
      iF = foldedIndex(pcNextF);
      iE = foldedIndex(mRec[0].pc);
      iW = foldedIndex(mRec[2].pc);
      // stale speculative entry means committed history
      hF = mValidQ ? mShbRd : mBhtRd;
      shbWr = brD.isBranch && !ctrl.e.stall && !ctrl.e.flush;
      commit = mRec[2].isBranch && !ctrl.w.stall && !ctrl.w.flush;
      // reads see the tables from before this edge
      predNext = ctrl.d.stall ? mPred : mPht[hF];
      if (!ctrl.f.stall) begin
        mBhtRd = mBht[iF];
        mShbRd = mShb[iF];
        mValidQ = mValidArr[iF];
      end
      if (shbWr) begin
        mShb[iE] = {mPred[1], mSlot[0].hist[histBits-1:1]};
      end
      if (commit) begin
        mBht[iW] = {mRec[2].taken, mSlot[2].hist[histBits-1:1]};
        mPht[mSlot[2].hist] = mSlot[2].pred;
      end
      // repair drops all speculative entries, the leaving branch survives
      if (ctrl.d.flush) begin
        mValidArr = '0;
      end
      if (shbWr) begin
        mValidArr[iE] = 1'b1;
      end
      // stages in w, m, e order so each takes the old upstream value
      if (ctrl.w.flush) begin
        mSlot[2] = '0;
        mRec[2] = '0;
      end else if (!ctrl.w.stall) begin
        mSlot[2].hist = mSlot[1].hist;
        mSlot[2].pred = satCount(mSlot[1].pred, mRec[1].taken);
        mRec[2] = mRec[1];
      end
      if (ctrl.m.flush) begin
        mSlot[1] = '0;
        mRec[1] = '0;
      end else if (!ctrl.m.stall) begin
        mSlot[1] = mSlot[0];
        mRec[1] = mRec[0];
        mRec[1].taken = takenE;
      end
      if (ctrl.e.flush) begin
        mSlot[0] = '0;
        mRec[0] = '0;
      end else if (!ctrl.e.stall) begin
        mSlot[0].hist = mHistD;
        mSlot[0].pred = mPred;
        mRec[0] = brD;
      end
      if (ctrl.d.flush) begin
        mHistD = '0;
      end else if (!ctrl.d.stall) begin
        mHistD = hF;
      end
      mPred = predNext;
    end
  endtask

  always @(posedge clk) begin
    modelStep();
  end

  //////////////////////////////
  // checks and stimulus
  //////////////////////////////

  task automatic checkPred(input bpPkg::ctrStateT got, input bpPkg::ctrStateT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[ERROR] dirPredD got 0x%h expected 0x%h at cycle %0d", got, exp, cycleNo);
    end
  endtask

  task automatic checkWrong(input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[ERROR] dirWrongE got 0x%h expected 0x%h at cycle %0d", got, exp, cycleNo);
    end
  endtask

  // one cycle, inputs on the falling edge, outputs sampled just after
  task automatic runCycle(input logic [bpPkg::xlen-1:0] pcIn, input logic brIn,
                          input bpPkg::pipeCtrlT ctrlIn);
    logic expWrong;
    @(negedge clk);
    ctrl = ctrlIn;
    pcNextF = pcIn;
    // the record reaching d was fetched two cycles back
    brD = decodeRec;
    decodeRec = fetchRec;
    fetchRec.pc = pcIn;
    fetchRec.isBranch = brIn;
    fetchRec.taken = 1'b0;
    takenE = resolveDir(mRec[0]);
    #1;
    cycleNo++;
    expWrong = mRec[0].isBranch && (takenE != mSlot[0].pred[1]);
    checkPred(dirPredD, mPred);
    checkWrong(dirWrongE, expWrong);
    if (mRec[0].isBranch) begin
      eBranches++;
    end
    pendingWrong = expWrong;
  endtask

  // one branch then seven plain instructions, lets w commit before the next fetch
  task automatic runGroup(input logic [bpPkg::xlen-1:0] pc);
    runCycle(pc, 1'b1, '0);
    for (int j = 1; j < 8; j++) begin
      runCycle(pc + 32'(4 * j), 1'b0, '0);
    end
  endtask

  task automatic randomCycle(input logic useStalls, input logic useFlush);
    logic [31:0]            r;
    logic [bpPkg::xlen-1:0] pc;
    logic                   brIn;
    bpPkg::pipeCtrlT        c;
    c = '0;
    r = randBits(7);
    // small pc window so entries alias, bit 1 included
    pc = 32'h0000_1000 | {24'h0, r[6:0], 1'b0};
    r = randBits(2);
    brIn = r[1:0] != 2'b00;
    if (useStalls) begin
      c.f.stall = quarterBit();
      c.d.stall = quarterBit();
      c.e.stall = quarterBit();
      c.m.stall = quarterBit();
      c.w.stall = quarterBit();
    end
    // d flush after a misprediction, half the time
    if (useFlush && pendingWrong) begin
      r = randBits(1);
      c.d.flush = r[0];
      if (r[0]) begin
        flushCount++;
      end
    end
    runCycle(pc, brIn, c);
  endtask

  task automatic startTest();
    testErr = errCount;
    testChecks = checkCount;
    tries = 0;
  endtask

  task automatic endTest(input string name);
    $display("test %s: %0d checks, %0d errors", name, checkCount - testChecks,
             errCount - testErr);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    lfsrState = 32'hf526448a;
    rstN = 1'b0;
    ctrl = '0;
    pcNextF = '0;
    brD = '0;
    // a branch waits in d through reset and must leave no trace
    brD.isBranch = 1'b1;
    takenE = 1'b0;
    fetchRec = '0;
    decodeRec = '0;
    dirMode = 0;
    altA = 1'b0;
    pendingWrong = 1'b0;
    cycleNo = 0;
    checkCount = 0;
    errCount = 0;
    eBranches = 0;
    flushCount = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    brD = '0;

    startTest();
    for (int i = 0; i < 5; i++) begin
      runCycle('0, 1'b0, '0);
      checkPred(dirPredD, 2'b00);
      checkWrong(dirWrongE, 1'b0);
    end
    endTest("reset");

    startTest();
    while (mPht[{histBits{1'b1}}] != 2'd3 && tries < 40) begin
      runGroup(pcA);
      tries++;
    end
    if (mPht[{histBits{1'b1}}] != 2'd3) begin
      errCount++;
      $display("training timed out, counter never reached 3");
    end
    // stays at 3 under more taken outcomes
    runGroup(pcA);
    runGroup(pcA);
    if (mPht[{histBits{1'b1}}] != 2'd3) begin
      errCount++;
      $display("counter left 3 after more taken outcomes");
    end
    endTest("training");

    startTest();
    dirMode = 1;
    for (int g = 0; g < 12; g++) begin
      runGroup(pcA);
      runGroup(pcB);
    end
    if (mBht[foldedIndex(pcA)] != 10'h2aa && mBht[foldedIndex(pcA)] != 10'h155) begin
      errCount++;
      $display("alternating branch history is not an alternating pattern");
    end
    if (mBht[foldedIndex(pcB)] != '1) begin
      errCount++;
      $display("always taken branch history picked up other outcomes");
    end
    endTest("local history");

    startTest();
    dirMode = 2;
    while (flushCount < 10 && tries < 1500) begin
      randomCycle(1'b0, 1'b1);
      tries++;
    end
    if (flushCount < 10) begin
      errCount++;
      $display("repair timed out, too few d flushes after mispredictions");
    end
    endTest("repair");

    startTest();
    for (int i = 0; i < 300; i++) begin
      randomCycle(1'b1, 1'b0);
    end
    endTest("stalls");

    startTest();
    eBranches = 0;
    while (eBranches < 50 && tries < 400) begin
      randomCycle(1'b0, 1'b0);
      tries++;
    end
    if (eBranches < 50) begin
      errCount++;
      $display("mispredict test timed out, too few branches reached e");
    end
    endTest("mispredict flag");

    $display("checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_props.sv */
`default_nettype none

// table write rules of the predictor
module predictorProps (
  input logic            clk,
  input logic            rstN,
  input bpPkg::pipeCtrlT ctrl,
  input bpPkg::brRecT    recD,
  input bpPkg::brRecT    recE,
  input bpPkg::brRecT    recM,
  input bpPkg::brRecT    recW,
  input logic            shbWrEn,
  input logic            commitEn,
  input logic            anyValid,
  input logic            dirWrongE
);

  //////////////////////////////
  // write rules
  //////////////////////////////

  // speculative write belongs to the branch that e takes in
  shbOnBranch: assert property (@(posedge clk)
    rstN && shbWrEn |=> recE.isBranch)
    else $error("shb write for a record that did not reach e as a branch");

  // commit belongs to a branch that came from m, or sat in w through a stall
  commitOnBranch: assert property (@(posedge clk) disable iff (!rstN)
    commitEn |-> $past(ctrl.w.stall ? recW.isBranch : recM.isBranch))
    else $error("bht or pht write without a branch reaching w");

  // a branch held in d through reset leaves every valid bit clear
  noWriteInReset: assert property (@(posedge clk)
    !rstN |=> !anyValid)
    else $error("valid bit set while reset was held");

  // e was flushed or took in a non-branch, so nothing to mispredict
  wrongNeedsBranch: assert property (@(posedge clk) disable iff (!rstN)
    $past(ctrl.e.flush || (ctrl.e.stall ? !recE.isBranch : !recD.isBranch))
    |-> !dirWrongE)
    else $error("dirWrongE high with no branch in e");

endmodule

bind localRepairBp predictorProps props (
  .clk       (clk),
  .rstN      (rstN),
  .ctrl      (ctrl),
  .recD      (recD),
  .recE      (recE),
  .recM      (recM),
  .recW      (recW),
  .shbWrEn   (shbWrEn),
  .commitEn  (commitEn),
  .anyValid  (|specValid.validArr),
  .dirWrongE (dirWrongE)
);

`default_nettype wire
